/* rtl/popeye_video_pkg.sv */
package popeye_video_pkg;

    // 32 color PROM entries
    localparam int PAL_AW = 5;

    // Color output, 3 bits per gun
    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [2:0] blue;
    } rgb_t;

    // Color PROM byte as the board wires it, red in the low bits
    typedef struct packed {
        logic [1:0] blue;   // Two bits only, LSB added on output
        logic [2:0] green;
        logic [2:0] red;
    } pal_entry_t;

    // Same PROM word, loaded as a byte and read as a color
    typedef union packed {
        logic [7:0] raw;
        pal_entry_t color;
    } pal_byte_u;

    // Blanking and sync, all active high
    typedef struct packed {
        logic hb;
        logic vb;
        logic hs;
        logic vs;
    } sync_t;

endpackage

/* rtl/popeye_rom_pkg.sv */
package popeye_rom_pkg;

    // Byte address width of the download stream
    localparam int ioctl_aw = 22;

    // Download map
    // Bytes below PROM_START are program and graphics ROM for the SDRAM
    // Bytes from PROM_START on are the color PROM contents
    localparam logic [ioctl_aw-1:0] PROM_START = 22'h00_c000;

    // SDRAM programming port, 16-bit words
    typedef struct packed {
        logic [ioctl_aw-1:0] addr;  // Word address
        logic [7:0]          data;  // Same byte on both lanes
        logic [1:0]          mask;  // Active low lane enables
        logic                we;
    } prog_t;

endpackage

/* rtl/popeye_cen.sv */
`timescale 1ns/1ps

module popeye_cen (
    input  logic clk,       // 20 MHz
    input  logic reset,
    output logic pxl2_cen,  // 10 MHz, object pixels
    output logic pxl_cen,   // 5 MHz, text pixels
    output logic cpu_cen    // 2.5 MHz
);

    // Free running divider
    logic [2:0] cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= 3'd0;
        end else begin
            cnt <= cnt + 3'd1;
        end
    end

    // Each enable is high for a single clk
    assign pxl2_cen = cnt[0];
    assign pxl_cen  = &cnt[1:0];  // Counts 3 and 7
    assign cpu_cen  = &cnt;       // Count 7 only

    // Slower enable must sit on the faster one
    a_pxl_on_pxl2: assert property (
        @(posedge clk) disable iff (reset)
        pxl_cen |-> pxl2_cen
    ) else $error("pxl_cen without pxl2_cen");

endmodule

/* rtl/popeye_vtiming.sv */
`timescale 1ns/1ps

module popeye_vtiming import popeye_video_pkg::*; #(
    parameter int H_TOTAL  = 320,
    parameter int H_ACTIVE = 256,
    parameter int HS_START = 272,
    parameter int HS_END   = 303,
    parameter int V_TOTAL  = 264,
    parameter int V_ACTIVE = 224,
    parameter int VS_START = 240,
    parameter int VS_END   = 243
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  pxl_cen,
    output sync_t sync
);

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);
    localparam logic [HW-1:0] H_LAST = HW'(H_TOTAL - 1);
    localparam logic [VW-1:0] V_LAST = VW'(V_TOTAL - 1);

    logic [HW-1:0] h;  // Pixel within the line
    logic [VW-1:0] v;  // Line within the frame

    always_ff @(posedge clk) begin
        if (reset) begin
            h <= '0;
            v <= '0;
        end else if (pxl_cen) begin
            if (h == H_LAST) begin
                h <= '0;
                v <= (v == V_LAST) ? '0 : v + 1'b1;  // New line
            end else begin
                h <= h + 1'b1;
            end
        end
    end

    // Window compares, one clk behind the counters
    always_ff @(posedge clk) begin
        if (reset) begin
            sync <= '0;
        end else begin
            sync.hb <= h >= HW'(H_ACTIVE);
            sync.hs <= (h >= HW'(HS_START)) && (h <= HW'(HS_END));
            sync.vb <= v >= VW'(V_ACTIVE);
            sync.vs <= (v >= VW'(VS_START)) && (v <= VW'(VS_END));
        end
    end

    a_cnt_range: assert property (
        @(posedge clk) disable iff (reset)
        (int'(h) < H_TOTAL) && (int'(v) < V_TOTAL)
    ) else $error("Video counter out of range h=%0d v=%0d", h, v);

endmodule

/* rtl/popeye_prom_we.sv */
`timescale 1ns/1ps

module popeye_prom_we
    import popeye_video_pkg::*;
    import popeye_rom_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                downloading,
    input  logic [ioctl_aw-1:0] ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    output prog_t               prog,
    output logic                pal_we,
    output logic [PAL_AW-1:0]   pal_addr,
    output pal_byte_u           pal_din
);

    logic                is_rom;
    logic [ioctl_aw-1:0] pal_off;

    assign is_rom  = ioctl_addr < PROM_START;
    assign pal_off = ioctl_addr - PROM_START;  // Offset inside the PROM region

    always_ff @(posedge clk) begin
        prog.we <= 1'b0;  // Write strobes last one clk
        pal_we  <= 1'b0;
        if (downloading && ioctl_wr) begin
            if (is_rom) begin
                prog.addr <= {1'b0, ioctl_addr[ioctl_aw-1:1]};  // Byte to word
                prog.data <= ioctl_data;
                // Even byte on lane 0, odd byte on lane 1
                prog.mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
                prog.we   <= 1'b1;
            end else begin
                pal_addr    <= pal_off[PAL_AW-1:0];
                pal_din.raw <= ioctl_data;
                pal_we      <= 1'b1;
            end
        end
        if (reset) begin
            prog.we <= 1'b0;
            pal_we  <= 1'b0;
        end
    end

    // A byte goes to the SDRAM or to the color PROM, never both
    a_one_target: assert property (
        @(posedge clk) disable iff (reset)
        !(prog.we && pal_we)
    ) else $error("SDRAM and palette written together");

endmodule

/* rtl/popeye_boot_fsm.sv */
`timescale 1ns/1ps

module popeye_boot_fsm #(
    parameter int READY_SETTLE = 2  // clk cycles from ready to CPU start
) (
    input  logic clk,
    input  logic reset,
    input  logic downloading,
    input  logic ready,        // ROM controller has data
    output logic main_reset
);

    localparam int CW = $clog2(READY_SETTLE + 1);

    typedef enum logic [1:0] {HOLD, SETTLE, RUN} state_t;

    state_t        state, state_nx;
    logic [CW-1:0] cnt;
    logic          go;

    assign go = ready && !downloading;

    always_comb begin
        state_nx = state;
        if (!go) begin
            state_nx = HOLD;  // Any loss of ROM drops back
        end else begin
            case (state)
                HOLD:    state_nx = (READY_SETTLE <= 1) ? RUN : SETTLE;
                SETTLE:  state_nx = (cnt == CW'(READY_SETTLE - 1)) ? RUN : SETTLE;
                default: state_nx = RUN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= HOLD;
            cnt        <= '0;
            main_reset <= 1'b1;
        end else begin
            state      <= state_nx;
            cnt        <= (state == SETTLE) ? cnt + 1'b1 : CW'(1);
            main_reset <= state_nx != RUN;  // Registered to keep the CPU reset clean
        end
    end

    // CPU stays in reset from the clk after a download starts
    a_hold_on_dl: assert property (
        @(posedge clk) disable iff (reset)
        downloading |=> main_reset
    ) else $error("Main CPU running during download");

endmodule

/* rtl/popeye_palette.sv */
`timescale 1ns/1ps

module popeye_palette import popeye_video_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              pxl_cen,
    input  sync_t             sync,
    input  logic              pal_we,
    input  logic [PAL_AW-1:0] pal_addr,
    input  pal_byte_u         pal_din,
    input  logic [PAL_AW-1:0] pxl_idx,
    output rgb_t              rgb
);

    pal_byte_u  pal_mem [0:2**PAL_AW-1];  // Color PROM
    pal_entry_t col;
    logic       blank;

    // Loaded byte-wise from the download stream
    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_mem[pal_addr].raw <= pal_din.raw;
        end
    end

    assign col   = pal_mem[pxl_idx].color;
    assign blank = sync.hb || sync.vb;

    always_ff @(posedge clk) begin
        if (reset) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            if (blank) begin
                rgb <= '0;  // Black outside active video
            end else begin
                rgb.red   <= col.red;
                rgb.green <= col.green;
                rgb.blue  <= {col.blue, 1'b0};  // LSB is always zero
            end
        end
    end

endmodule

/* rtl/popeye_game.sv */
`timescale 1ns/1ps

module popeye_game
    import popeye_video_pkg::*;
    import popeye_rom_pkg::*;
#(
    parameter int H_TOTAL      = 320,
    parameter int H_ACTIVE     = 256,
    parameter int HS_START     = 272,
    parameter int HS_END       = 303,
    parameter int V_TOTAL      = 264,
    parameter int V_ACTIVE     = 224,
    parameter int VS_START     = 240,
    parameter int VS_END       = 243,
    parameter int READY_SETTLE = 2
) (
    input  logic                clk,          // 20 MHz
    input  logic                reset,
    input  logic                downloading,
    input  logic [ioctl_aw-1:0] ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    input  logic                ready,        // From the ROM controller
    input  logic [PAL_AW-1:0]   pxl_idx,      // From the tile and sprite mixer
    output prog_t               prog,
    output logic                main_reset,
    output logic                pxl2_cen,
    output logic                pxl_cen,
    output logic                cpu_cen,
    output sync_t               sync,
    output rgb_t                rgb
);

    logic              pal_we;
    logic [PAL_AW-1:0] pal_addr;
    pal_byte_u         pal_din;

    popeye_cen u_cen (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  ),
        .cpu_cen  ( cpu_cen  )
    );

    popeye_vtiming #(
        .H_TOTAL  ( H_TOTAL  ),
        .H_ACTIVE ( H_ACTIVE ),
        .HS_START ( HS_START ),
        .HS_END   ( HS_END   ),
        .V_TOTAL  ( V_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .VS_START ( VS_START ),
        .VS_END   ( VS_END   )
    ) u_vtiming (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pxl_cen  ( pxl_cen  ),
        .sync     ( sync     )
    );

    popeye_prom_we u_prom_we (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog        ( prog        ),  // Mask is active low
        .pal_we      ( pal_we      ),
        .pal_addr    ( pal_addr    ),
        .pal_din     ( pal_din     )
    );

    popeye_boot_fsm #(
        .READY_SETTLE ( READY_SETTLE )
    ) u_boot_fsm (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ready       ( ready       ),
        .main_reset  ( main_reset  )
    );

    popeye_palette u_palette (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pxl_cen  ( pxl_cen  ),
        .sync     ( sync     ),
        .pal_we   ( pal_we   ),
        .pal_addr ( pal_addr ),
        .pal_din  ( pal_din  ),
        .pxl_idx  ( pxl_idx  ),
        .rgb      ( rgb      )
    );

endmodule

/* bench/popeye_game_tb_table.svh */
`ifndef POPEYE_GAME_TB_TABLE_SVH
`define POPEYE_GAME_TB_TABLE_SVH

// Columns: PROM byte, pixel index, expected rgb
// Byte is blue[7:6] green[5:3] red[2:0], rgb is red green blue at 3 bits each
typedef struct packed {
    logic [7:0]        pal;
    logic [PAL_AW-1:0] idx;
    rgb_t              rgb;
} pal_case_t;

localparam int N_PAL = 8;

pal_case_t pal_table [N_PAL] = '{
    {8'h07, 5'd0,  9'h1c0},  // Red only
    {8'h38, 5'd1,  9'h038},
    {8'hc0, 5'd2,  9'h006},  // Blue LSB stays clear
    {8'hff, 5'd31, 9'h1fe},
    {8'h00, 5'd5,  9'h000},
    {8'h5a, 5'd10, 9'h09a},
    {8'ha5, 5'd17, 9'h164},
    {8'h93, 5'd23, 9'h0d4}
};

`endif

/* bench/popeye_game_tb.sv */
`timescale 1ns/1ps

module popeye_game_tb
    import popeye_video_pkg::*;
    import popeye_rom_pkg::*;
();

    logic                clk         = 1'b0;
    logic                reset       = 1'b1;
    logic                downloading = 1'b0;
    logic [ioctl_aw-1:0] ioctl_addr  = '0;
    logic [7:0]          ioctl_data  = '0;
    logic                ioctl_wr    = 1'b0;
    logic                ready       = 1'b0;
    logic [PAL_AW-1:0]   pxl_idx     = '0;
    prog_t               prog;
    logic                main_reset;
    logic                pxl2_cen;
    logic                pxl_cen;
    logic                cpu_cen;
    sync_t               sync;
    rgb_t                rgb;

    int    errors       = 0;
    int    test_errs    = 0;  // Error count when the current test started
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    n, j, seed, blk, syn, lead, blank_seen;
    int    last [3];
    string cen_name [3] = '{"pxl2_cen", "pxl_cen", "cpu_cen"};
    logic [2:0]          en;
    logic                was_blank;
    logic [ioctl_aw-1:0] addr;
    logic [7:0]          data;
    prog_t               exp_prog;
    logic [ioctl_aw-1:0] rom_q [$];

    `include "popeye_game_tb_table.svh"

    always #2 clk = ~clk;  // 4 ns period

    popeye_game #(
        .H_TOTAL  ( 16 ), .H_ACTIVE ( 12 ), .HS_START ( 13 ), .HS_END ( 14 ),
        .V_TOTAL  ( 8  ), .V_ACTIVE ( 6  ), .VS_START ( 7  ), .VS_END ( 7  ),
        .READY_SETTLE ( 2 )
    ) u_popeye_game (.*);

    // Inputs change and outputs are read 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
        $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
        errors++;
    endtask

    task automatic report_problem(string what);
        $display("ERROR: %s", what);
        errors++;
    endtask

    task automatic close_test(string name);
        tests_run++;
        if (errors != test_errs) begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - test_errs);
        end else begin
            $display("Test %s: ok", name);
        end
        test_errs = errors;
    endtask

    // One download strobe, returns on the clk where its result shows
    task automatic write_byte(logic [ioctl_aw-1:0] a, logic [7:0] d);
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        step();
        ioctl_wr = 1'b0;
    endtask

    function automatic logic blank_sel(bit vert);
        return vert ? sync.vb : sync.hb;
    endfunction

    function automatic logic sync_sel(bit vert);
        return vert ? sync.vs : sync.hs;
    endfunction

    // Pixel enables inside one blanking window, inside its sync, and ahead of the sync
    task automatic measure_window(input bit vert, output int b, output int s, output int l);
        int   cnt;
        logic prev;
        b    = 0;
        s    = 0;
        l    = 0;
        cnt  = 0;
        prev = 1'b1;  // Only a real rising edge counts
        while (!(blank_sel(vert) && !prev) && cnt < 1000) begin
            prev = blank_sel(vert);
            step();
            cnt++;
        end
        if (cnt == 1000) report_problem("timeout waiting for blanking to start");
        while (blank_sel(vert) && cnt < 2000) begin
            if (pxl_cen && sync_sel(vert)) s++;
            if (pxl_cen && !sync_sel(vert) && s == 0) l++;
            b += pxl_cen;
            step();
            cnt++;
        end
        if (cnt == 2000) report_problem("timeout waiting for blanking to end");
    endtask

    initial begin
        seed = $urandom(32'hab94_8ab2);
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Counter restarts at 0, so pxl_cen shows in the 4th cycle
        n = 1;
        while (!pxl_cen && n < 16) begin
            step();
            n++;
        end
        if (!pxl_cen) report_problem("timeout waiting for the first pxl_cen");
        else if (n != 4) report_mismatch("first pxl_cen cycle", 4, n);
        last = '{-1, -1, -1};
        for (int c = 0; c < 32; c++) begin
            en = {cpu_cen, pxl_cen, pxl2_cen};
            for (int k = 0; k < 3; k++) begin
                if (en[k]) begin
                    if (last[k] >= 0 && c - last[k] != (2 << k))
                        report_mismatch({cen_name[k], " period"}, 2 << k, c - last[k]);
                    last[k] = c;
                end
            end
            step();
        end
        for (int k = 0; k < 3; k++) begin
            if (last[k] < 0) report_problem({cen_name[k], " never pulsed"});
        end
        close_test("enables");

        measure_window(1'b0, blk, syn, lead);
        if (blk != 4) report_mismatch("hb pixels", 4, blk);
        if (syn != 2) report_mismatch("hs pixels", 2, syn);
        if (lead != 1) report_mismatch("hb to hs pixels", 1, lead);
        measure_window(1'b1, blk, syn, lead);
        if (blk != 2 * 16) report_mismatch("vb pixels", 2 * 16, blk);
        if (syn != 16) report_mismatch("vs pixels", 16, syn);
        if (lead != 16) report_mismatch("vb to vs pixels", 16, lead);
        close_test("sync");

        downloading = 1'b1;
        for (int i = 0; i < 8; i++) begin
            rom_q.push_back(22'h00_1230 + i);
        end
        while (rom_q.size() > 0) begin
            j = $urandom % rom_q.size();  // Random write order
            addr = rom_q[j];
            rom_q.delete(j);
            data = $urandom;
            write_byte(addr, data);
            exp_prog = {addr >> 1, data, addr[0] ? 2'b01 : 2'b10, 1'b1};
            if (prog !== exp_prog) report_mismatch("rom prog", exp_prog, prog);
            if (u_popeye_game.pal_we !== 1'b0) report_problem("palette written by a ROM byte");
            if (main_reset !== 1'b1) report_problem("main_reset low during download");
            step();
            if (prog.we !== 1'b0) report_problem("prog.we high for more than one clk");
        end
        close_test("rom_download");

        for (int i = 0; i < N_PAL; i++) begin
            write_byte(PROM_START + pal_table[i].idx, pal_table[i].pal);
            if (prog.we !== 1'b0) report_problem("SDRAM written by a palette byte");
            step();
        end
        downloading = 1'b0;
        for (int i = 0; i < N_PAL; i++) begin
            pxl_idx = pal_table[i].idx;
            n = 0;
            while (!(pxl_cen && !sync.hb && !sync.vb) && n < 1000) begin
                step();
                n++;
            end
            if (n == 1000) report_problem("timeout waiting for an active pixel");
            step();
            if (rgb !== pal_table[i].rgb) report_mismatch("palette rgb", pal_table[i].rgb, rgb);
        end
        close_test("palette");

        // One full frame of 512 clk with a bright color selected
        pxl_idx    = pal_table[3].idx;
        blank_seen = 0;
        for (int c = 0; c < 512; c++) begin
            was_blank = pxl_cen && (sync.hb || sync.vb);
            step();
            if (was_blank) begin
                blank_seen++;
                if (rgb !== '0) report_mismatch("blank rgb", 0, rgb);
            end
        end
        if (blank_seen != 4 * 6 + 2 * 16) report_mismatch("blank pixels", 56, blank_seen);
        close_test("blanking");

        for (int c = 0; c < 8; c++) begin
            if (main_reset !== 1'b1) report_problem("main_reset low while ready is low");
            step();
        end
        ready = 1'b1;
        n = 0;
        while (main_reset && n < 20) begin
            step();
            n++;
        end
        if (main_reset) report_problem("timeout waiting for main_reset to fall");
        else if (n != 2) report_mismatch("main_reset release delay", 2, n);
        downloading = 1'b1;  // New download takes the CPU back into reset
        n = 0;
        while (!main_reset && n < 20) begin
            step();
            n++;
        end
        if (!main_reset) report_problem("timeout waiting for main_reset to rise");
        else if (n != 1) report_mismatch("main_reset hold delay", 1, n);
        close_test("boot");

        $display("Tests run: %0d, tests with errors: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+bench
rtl/popeye_video_pkg.sv
rtl/popeye_rom_pkg.sv
rtl/popeye_cen.sv
rtl/popeye_vtiming.sv
rtl/popeye_prom_we.sv
rtl/popeye_boot_fsm.sv
rtl/popeye_palette.sv
rtl/popeye_game.sv
bench/popeye_game_tb.sv
